// File: hw/vc_router_pkg.sv
// Shared types for the five-port virtual-channel mesh router.
// Packets are single flits and a flit keeps its VC id through the router.
// VC ids are 2 bits wide, so one router supports at most 4 VCs.
`default_nettype none

package vc_router_pkg;

  localparam int NumPorts     = 5;
  localparam int VcIdWidth    = 2;
  localparam int MaxVc        = 1 << VcIdWidth;
  localparam int CoordWidth   = 4;
  localparam int PayloadWidth = 16;
  // widest request vector that rr_pick accepts
  localparam int RrWidth      = 8;

  // output directions, also used as port indices
  typedef enum logic [2:0] {
    port_north = 3'd0,
    port_east  = 3'd1,
    port_south = 3'd2,
    port_west  = 3'd3,
    port_local = 3'd4
  } port_e;

  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } coord_t;

  typedef struct packed {
    logic [VcIdWidth-1:0]    vc_id;
    coord_t                  dst;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

  // one direction of a data link
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

  typedef struct packed {
    logic                 valid;
    logic [VcIdWidth-1:0] vc_id;
  } credit_t;

  // offer of one input port to the switch allocator
  // head_port holds the XY target of every VC head, for the credit check
  typedef struct packed {
    logic                 valid;
    port_e                port;
    logic [VcIdWidth-1:0] vc_id;
    flit_t                flit;
    port_e [MaxVc-1:0]    head_port;
  } req_t;

  // first set request at or after ptr, wrapping at n; returns n when none is set
  function automatic int unsigned rr_pick(input logic [RrWidth-1:0] req,
                                          input int unsigned        ptr,
                                          input int unsigned        n);
    int unsigned idx;
    int unsigned pick;
    pick = n;
    for (int unsigned k = 0; k < RrWidth; k++) begin
      idx = ptr + k;
      if (idx >= n) begin
        idx = idx - n;
      end
      if (k < n && idx < RrWidth && req[idx] && pick == n) begin
        pick = idx;
      end
    end
    return pick;
  endfunction

endpackage

`default_nettype wire

// File: hw/vc_input_port.sv
// Input port with one FIFO of VcDepth flits per VC, written by the flit's VC id.
// The upstream sender must hold a credit before it sends, no overflow check here.
// XY routing: x is corrected first, then y; y grows towards north.
`timescale 1ns/1ps
`default_nettype none

module vc_input_port #(
  parameter int NumVc   = 2,
  parameter int VcDepth = 2
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  vc_router_pkg::coord_t  router_xy_i,
  input  vc_router_pkg::link_t   link_i,
  output vc_router_pkg::credit_t credit_o,
  input  logic [NumVc-1:0]       vc_ready_i,
  output vc_router_pkg::req_t    req_o,
  input  logic                   grant_i
);
  import vc_router_pkg::*;

  localparam int PtrWidth = (VcDepth > 1) ? $clog2(VcDepth) : 1;
  localparam int CntWidth = $clog2(VcDepth + 1);

  flit_t                head_flit [NumVc];
  port_e                head_port [NumVc];
  logic [NumVc-1:0]     cand;
  logic [VcIdWidth-1:0] vc_ptr_q;
  logic [VcIdWidth-1:0] sel_vc;
  logic                 sel_valid;

  function automatic port_e xy_route(input coord_t dst, input coord_t here);
    port_e dir;
    if (dst.x > here.x) begin
      dir = port_east;
    end else if (dst.x < here.x) begin
      dir = port_west;
    end else if (dst.y > here.y) begin
      dir = port_north;
    end else if (dst.y < here.y) begin
      dir = port_south;
    end else begin
      dir = port_local;
    end
    return dir;
  endfunction

  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(VcDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ==================================================
  // per-VC FIFOs
  // ==================================================
  for (genvar v = 0; v < NumVc; v++) begin : gen_vc
    flit_t               mem_q [VcDepth];
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                push;
    logic                pop;

    assign push = link_i.valid && (link_i.flit.vc_id == VcIdWidth'(v));
    assign pop  = grant_i && (sel_vc == VcIdWidth'(v));

    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= link_i.flit;
      end
    end

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        count_q <= count_q + CntWidth'(push) - CntWidth'(pop);
      end
    end

    assign head_flit[v] = mem_q[rd_ptr_q];
    assign head_port[v] = xy_route(mem_q[rd_ptr_q].dst, router_xy_i);
    // a head only competes when its output VC has a free slot downstream
    assign cand[v]      = (count_q != '0) && vc_ready_i[v];
  end

  // ==================================================
  // round-robin over ready VCs
  // ==================================================
  always_comb begin
    logic [RrWidth-1:0] cand_ext;
    int unsigned        pick;
    cand_ext            = '0;
    cand_ext[NumVc-1:0] = cand;
    pick                = rr_pick(cand_ext, 32'(vc_ptr_q), NumVc);
    sel_valid           = (pick < NumVc);
    sel_vc              = sel_valid ? VcIdWidth'(pick) : '0;
  end

  always_comb begin
    req_o       = '0;
    req_o.valid = sel_valid;
    req_o.vc_id = sel_vc;
    for (int v = 0; v < NumVc; v++) begin
      req_o.head_port[v] = head_port[v];
      if (sel_vc == VcIdWidth'(v)) begin
        req_o.port = head_port[v];
        req_o.flit = head_flit[v];
      end
    end
  end

  // pointer moves past a VC only once it has actually been served
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vc_ptr_q <= '0;
      credit_o <= '0;
    end else begin
      credit_o.valid <= grant_i;
      credit_o.vc_id <= sel_vc;
      if (grant_i) begin
        vc_ptr_q <= (sel_vc == VcIdWidth'(NumVc - 1)) ? '0 : sel_vc + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/vc_switch_allocator.sv
// Output side of separable switch allocation, purely combinational to grants.
// Keeps one credit counter per output and VC, reset to VcDepth.
// A credit_i pulse is usable from the cycle after it is sampled.
`timescale 1ns/1ps
`default_nettype none

module vc_switch_allocator #(
  parameter int NumVc   = 2,
  parameter int VcDepth = 2
) (
  input  logic                                                               clk_i,
  input  logic                                                               reset_i,
  input  vc_router_pkg::req_t    [vc_router_pkg::NumPorts-1:0]               req_i,
  input  vc_router_pkg::credit_t [vc_router_pkg::NumPorts-1:0]               credit_i,
  output logic [vc_router_pkg::NumPorts-1:0][NumVc-1:0]                      vc_ready_o,
  output logic [vc_router_pkg::NumPorts-1:0]                                 grant_o,
  output logic [vc_router_pkg::NumPorts-1:0][vc_router_pkg::NumPorts-1:0]    sel_o,
  output logic [vc_router_pkg::NumPorts-1:0]                                 sel_valid_o
);
  import vc_router_pkg::*;

  localparam int CntWidth = $clog2(VcDepth + 1);
  localparam int PtrWidth = $clog2(NumPorts);

  logic [NumPorts-1:0][NumVc-1:0][CntWidth-1:0] cnt_q;
  logic [NumPorts-1:0][PtrWidth-1:0]            rr_ptr_q;
  logic [NumPorts-1:0][PtrWidth-1:0]            win_idx;
  logic [NumPorts-1:0][VcIdWidth-1:0]           win_vc;
  logic [NumPorts-1:0][NumVc-1:0]               credit_inc;
  logic [NumPorts-1:0][NumVc-1:0]               grant_dec;

  // credit check for every buffered head, fed back to the input ports
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      for (int v = 0; v < NumVc; v++) begin
        vc_ready_o[i][v] = (cnt_q[req_i[i].head_port[v]][v] != '0);
      end
    end
  end

  // ==================================================
  // round-robin over inputs, one arbiter per output
  // ==================================================
  always_comb begin
    logic [RrWidth-1:0] req_vec;
    int unsigned        pick;
    sel_o       = '0;
    sel_valid_o = '0;
    win_idx     = '0;
    win_vc      = '0;
    for (int o = 0; o < NumPorts; o++) begin
      req_vec = '0;
      for (int i = 0; i < NumPorts; i++) begin
        req_vec[i] = req_i[i].valid && (req_i[i].port == port_e'(o));
      end
      pick = rr_pick(req_vec, 32'(rr_ptr_q[o]), NumPorts);
      if (pick < NumPorts) begin
        sel_valid_o[o]    = 1'b1;
        sel_o[o][pick]    = 1'b1;
        win_idx[o]        = PtrWidth'(pick);
        win_vc[o]         = req_i[pick].vc_id;
      end
    end
  end

  // each input targets one output, so a column OR is its grant
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      grant_o[i] = 1'b0;
      for (int o = 0; o < NumPorts; o++) begin
        grant_o[i] = grant_o[i] | sel_o[o][i];
      end
    end
  end

  // ==================================================
  // credit counters
  // ==================================================
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int v = 0; v < NumVc; v++) begin
        credit_inc[o][v] = credit_i[o].valid && (credit_i[o].vc_id == VcIdWidth'(v));
        grant_dec[o][v]  = sel_valid_o[o] && (win_vc[o] == VcIdWidth'(v));
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q <= '0;
      for (int o = 0; o < NumPorts; o++) begin
        for (int v = 0; v < NumVc; v++) begin
          cnt_q[o][v] <= CntWidth'(VcDepth);
        end
      end
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        if (sel_valid_o[o]) begin
          rr_ptr_q[o] <= (win_idx[o] == PtrWidth'(NumPorts - 1)) ? '0 : win_idx[o] + 1'b1;
        end
        for (int v = 0; v < NumVc; v++) begin
          cnt_q[o][v] <= cnt_q[o][v] + CntWidth'(credit_inc[o][v]) - CntWidth'(grant_dec[o][v]);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/vc_crossbar.sv
// Switch traversal stage: registers the allocation result and each input's
// chosen flit, then muxes the registered flits onto the output links.
`timescale 1ns/1ps
`default_nettype none

module vc_crossbar (
  input  logic                                                            clk_i,
  input  logic                                                            reset_i,
  input  logic [vc_router_pkg::NumPorts-1:0][vc_router_pkg::NumPorts-1:0] sel_i,
  input  logic [vc_router_pkg::NumPorts-1:0]                              sel_valid_i,
  input  vc_router_pkg::flit_t [vc_router_pkg::NumPorts-1:0]              flit_i,
  output vc_router_pkg::link_t [vc_router_pkg::NumPorts-1:0]              link_o
);
  import vc_router_pkg::*;

  logic  [NumPorts-1:0][NumPorts-1:0] sel_q;
  logic  [NumPorts-1:0]               sel_valid_q;
  flit_t [NumPorts-1:0]               flit_q;

  // ==================================================
  // SA to ST register
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q       <= '0;
      sel_valid_q <= '0;
    end else begin
      sel_q       <= sel_i;
      sel_valid_q <= sel_valid_i;
    end
  end

  // the flit being popped this cycle is captured here
  always_ff @(posedge clk_i) begin
    flit_q <= flit_i;
  end

  // output muxes, select is one-hot per output
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      link_o[o].valid = sel_valid_q[o];
      link_o[o].flit  = '0;
      for (int i = 0; i < NumPorts; i++) begin
        if (sel_q[o][i]) begin
          link_o[o].flit = flit_q[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/vc_router.sv
// Five-port virtual-channel mesh router, single-flit packets, credit flow control.
// Ports are indexed north, east, south, west, local. NumVc must not exceed 4.
// Minimum latency from link_i to link_o is two clock edges.
`timescale 1ns/1ps
`default_nettype none

module vc_router #(
  parameter int NumVc   = 2,
  parameter int VcDepth = 2
) (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  vc_router_pkg::coord_t                                router_xy_i,
  input  vc_router_pkg::link_t   [vc_router_pkg::NumPorts-1:0] link_i,
  output vc_router_pkg::credit_t [vc_router_pkg::NumPorts-1:0] credit_o,
  output vc_router_pkg::link_t   [vc_router_pkg::NumPorts-1:0] link_o,
  input  vc_router_pkg::credit_t [vc_router_pkg::NumPorts-1:0] credit_i
);
  import vc_router_pkg::*;

  req_t  [NumPorts-1:0]               req;
  logic  [NumPorts-1:0][NumVc-1:0]    vc_ready;
  logic  [NumPorts-1:0]               grant;
  logic  [NumPorts-1:0][NumPorts-1:0] sel;
  logic  [NumPorts-1:0]               sel_valid;
  flit_t [NumPorts-1:0]               head_flit;

  // ==================================================
  // input ports
  // ==================================================
  for (genvar p = 0; p < NumPorts; p++) begin : gen_input_ports
    vc_input_port #(
      .NumVc       (NumVc),
      .VcDepth     (VcDepth)
    ) u_input_port (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .router_xy_i (router_xy_i),
      .link_i      (link_i[p]),
      .credit_o    (credit_o[p]),
      .vc_ready_i  (vc_ready[p]),
      .req_o       (req[p]),
      .grant_i     (grant[p])
    );

    assign head_flit[p] = req[p].flit;
  end

  // ==================================================
  // allocation and traversal
  // ==================================================
  vc_switch_allocator #(
    .NumVc       (NumVc),
    .VcDepth     (VcDepth)
  ) u_switch_allocator (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req),
    .credit_i    (credit_i),
    .vc_ready_o  (vc_ready),
    .grant_o     (grant),
    .sel_o       (sel),
    .sel_valid_o (sel_valid)
  );

  vc_crossbar u_crossbar (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .sel_i       (sel),
    .sel_valid_i (sel_valid),
    .flit_i      (head_flit),
    .link_o      (link_o)
  );

endmodule

`default_nettype wire

// File: sim/vc_router_checker.sv
// Assertions on the switch allocator, bound into every vc_switch_allocator.
// Reads the allocator's internal counters and winning VC ids.
`timescale 1ns/1ps
`default_nettype none

module vc_router_checker #(
  parameter int NumVc    = 2,
  parameter int VcDepth  = 2,
  parameter int CntWidth = $clog2(VcDepth + 1)
) (
  input logic                                                            clk_i,
  input logic                                                            reset_i,
  input logic [vc_router_pkg::NumPorts-1:0][vc_router_pkg::NumPorts-1:0] sel_o,
  input logic [vc_router_pkg::NumPorts-1:0]                              sel_valid_o,
  input logic [vc_router_pkg::NumPorts-1:0][vc_router_pkg::VcIdWidth-1:0] win_vc,
  input logic [vc_router_pkg::NumPorts-1:0][NumVc-1:0][CntWidth-1:0]    cnt_q
);
  import vc_router_pkg::*;

  // selects regrouped per input, one bit per output
  logic [NumPorts-1:0][NumPorts-1:0] sel_by_input;

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        sel_by_input[i][o] = sel_o[o][i];
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(sel_o[o]))
      else $error("output %0d selects more than one input", o);

    for (genvar v = 0; v < NumVc; v++) begin : gen_vc
      assert property (@(posedge clk_i) disable iff (reset_i)
          sel_valid_o[o] && (win_vc[o] == VcIdWidth'(v)) |-> cnt_q[o][v] != '0)
        else $error("output %0d granted VC %0d with no credit left", o, v);

      assert property (@(posedge clk_i) disable iff (reset_i)
          cnt_q[o][v] <= CntWidth'(VcDepth))
        else $error("credit counter of output %0d VC %0d above depth", o, v);
    end
  end

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(sel_by_input[i]))
      else $error("input %0d granted by more than one output", i);
  end

endmodule

bind vc_switch_allocator vc_router_checker #(
  .NumVc       (NumVc),
  .VcDepth     (VcDepth)
) u_checker (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .sel_o       (sel_o),
  .sel_valid_o (sel_valid_o),
  .win_vc      (win_vc),
  .cnt_q       (cnt_q)
);

`default_nettype wire

// File: sim/vc_router_tb.sv
// Testbench for the VC router placed at (2,2) in a 4x4 mesh, NumVc 2, VcDepth 2.
// Random single-flit traffic from a 16-bit Fibonacci LFSR with seed 83.
// Payload carries {source port, sequence number} for the scoreboard.
`timescale 1ns/1ps
`default_nettype none

module vc_router_tb;
  import vc_router_pkg::*;

  localparam int     NumVc         = 2;
  localparam int     VcDepth       = 2;
  localparam int     ClkPeriodNs   = 4;
  localparam int     ResetCycles   = 10;
  localparam int     IdleCycles    = 5;
  localparam int     RandomCycles  = 400;
  localparam int     StallCycles   = 60;
  localparam int     ResumeCycles  = 200;
  localparam int     MaxFlits      = NumPorts * (RandomCycles + StallCycles + ResumeCycles);
  localparam int     TimeoutCycles = MaxFlits * 20 + ResetCycles;
  localparam int     NumQueues     = NumPorts * NumPorts * NumVc;
  localparam coord_t RouterXy      = '{x: 4'd2, y: 4'd2};

  // downstream credit return modes
  localparam int CreditNone   = 0;
  localparam int CreditRandom = 1;
  localparam int CreditAll    = 2;

  logic                   clk_i;
  logic                   reset_i;
  link_t   [NumPorts-1:0] link_i;
  credit_t [NumPorts-1:0] credit_o;
  link_t   [NumPorts-1:0] link_o;
  credit_t [NumPorts-1:0] credit_i;

  logic [15:0] lfsr_q;
  int          up_cred   [NumPorts][NumVc];  // credits held by the upstream senders
  int          ds_cred   [NumPorts][NumVc];  // credits the router can grant on
  int          cred_pend [NumPorts][NumVc];  // credits driven last cycle, not yet sampled
  int          held      [NumPorts][NumVc];  // flits taken downstream whose credit is owed
  logic [12:0] seq       [NumPorts];
  flit_t       exp_q     [NumQueues][$];
  int          injected;
  int          delivered;

  vc_router #(
    .NumVc       (NumVc),
    .VcDepth     (VcDepth)
  ) u_vc_router (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .router_xy_i (RouterXy),
    .link_i      (link_i),
    .credit_o    (credit_o),
    .link_o      (link_o),
    .credit_i    (credit_i)
  );

  always #(ClkPeriodNs / 2) clk_i = ~clk_i;

  initial begin
    #(TimeoutCycles * ClkPeriodNs);
    fail_check("watchdog expired before all injected flits were delivered");
  end

  // ==================================================
  // model helpers
  // ==================================================
  // taps 16, 14, 13, 11; one step per returned bit
  function automatic logic [15:0] lfsr_bits(input int n);
    logic        fb;
    logic [15:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[14:0], fb};
    end
    return r;
  endfunction

  // x first, then y; north is the growing y direction
  function automatic int xy_port(input coord_t dst);
    if (dst.x > RouterXy.x) return int'(port_east);
    if (dst.x < RouterXy.x) return int'(port_west);
    if (dst.y > RouterXy.y) return int'(port_north);
    if (dst.y < RouterXy.y) return int'(port_south);
    return int'(port_local);
  endfunction

  function automatic int queue_index(input int out, input int src, input int vc);
    return (out * NumPorts + src) * NumVc + vc;
  endfunction

  task automatic end_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic fail_check(input string msg);
    $display("Error at %0t: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic compare_flit(input flit_t got, input flit_t exp, input int out);
    if (got !== exp) begin
      $display("Mismatch at %0t: output %0d got flit %h, expected %h", $time, out, got, exp);
      end_with_failure();
    end
  endtask

  task automatic compare_credit(input credit_t got, input credit_t exp, input int port);
    if (got !== exp) begin
      $display("Mismatch at %0t: credit_o[%0d] is %h, expected %h", $time, port, got, exp);
      end_with_failure();
    end
  endtask

  // ==================================================
  // per-cycle checks and stimulus
  // ==================================================
  task automatic check_idle();
    credit_t quiet;
    quiet = '0;
    for (int p = 0; p < NumPorts; p++) begin
      compare_credit(credit_o[p], quiet, p);
      if (link_o[p].valid) fail_check($sformatf("link_o[%0d] valid with nothing in flight", p));
    end
  endtask

  task automatic check_outputs();
    flit_t f;
    int    v;
    int    src;
    int    idx;
    for (int p = 0; p < NumPorts; p++) begin
      if (credit_o[p].valid) begin
        v = int'(credit_o[p].vc_id);
        if (v >= NumVc) fail_check($sformatf("credit_o[%0d] names VC %0d", p, v));
        if (up_cred[p][v] >= VcDepth) begin
          fail_check($sformatf("input %0d returned more credits than flits on VC %0d", p, v));
        end
        up_cred[p][v]++;
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      if (link_o[o].valid) begin
        f   = link_o[o].flit;
        v   = int'(f.vc_id);
        src = int'(f.payload[15:13]);
        if (v >= NumVc || src >= NumPorts) begin
          fail_check($sformatf("output %0d sent a flit with bad VC or source", o));
        end
        if (ds_cred[o][v] == 0) begin
          fail_check($sformatf("output %0d sent on VC %0d without a credit", o, v));
        end
        ds_cred[o][v]--;
        held[o][v]++;
        idx = queue_index(o, src, v);
        if (exp_q[idx].size() == 0) begin
          fail_check($sformatf("output %0d delivered a flit that was not expected there", o));
        end
        compare_flit(f, exp_q[idx].pop_front(), o);
        delivered++;
      end
    end
    // a credit driven last cycle was sampled on this edge and is usable from now on
    for (int o = 0; o < NumPorts; o++) begin
      for (int c = 0; c < NumVc; c++) begin
        ds_cred[o][c]   = ds_cred[o][c] + cred_pend[o][c];
        cred_pend[o][c] = 0;
      end
    end
  endtask

  task automatic drive_inputs(input logic inject, input int credit_mode);
    flit_t  f;
    coord_t dst;
    logic   go;
    logic   want;
    int     v;
    for (int p = 0; p < NumPorts; p++) begin
      link_i[p] = '0;
      if (inject) begin
        go    = (lfsr_bits(2) != 16'd0);
        v     = int'(lfsr_bits(VcIdWidth)) % NumVc;
        dst.x = CoordWidth'(lfsr_bits(2));
        dst.y = CoordWidth'(lfsr_bits(2));
        if (go && up_cred[p][v] > 0) begin
          f.vc_id   = VcIdWidth'(v);
          f.dst     = dst;
          f.payload = {3'(p), seq[p]};
          link_i[p] = '{valid: 1'b1, flit: f};
          up_cred[p][v]--;
          seq[p]++;
          exp_q[queue_index(xy_port(dst), p, v)].push_back(f);
          injected++;
        end
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      credit_i[o] = '0;
      want = (credit_mode == CreditAll) ||
             (credit_mode == CreditRandom && lfsr_bits(1) != 16'd0);
      v = int'(lfsr_bits(VcIdWidth)) % NumVc;
      // first VC that owes a credit, starting at the random one
      for (int k = 0; k < NumVc; k++) begin
        if (held[o][v] == 0) v = (v + 1) % NumVc;
      end
      if (want && held[o][v] > 0) begin
        credit_i[o] = '{valid: 1'b1, vc_id: VcIdWidth'(v)};
        held[o][v]--;
        cred_pend[o][v]++;
      end
    end
  endtask

  task automatic step(input logic inject, input int credit_mode);
    @(posedge clk_i);
    #0.5;
    check_outputs();
    drive_inputs(inject, credit_mode);
  endtask

  task automatic check_balance();
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVc; v++) begin
        if (up_cred[p][v] != VcDepth || ds_cred[p][v] != VcDepth || held[p][v] != 0) begin
          fail_check($sformatf("credits of port %0d VC %0d not balanced at the end", p, v));
        end
      end
    end
    if (injected == 0) fail_check("no flit was injected");
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    clk_i     = 1'b0;
    reset_i   = 1'b1;
    link_i    = '0;
    credit_i  = '0;
    lfsr_q    = 16'd83;
    injected  = 0;
    delivered = 0;
    for (int p = 0; p < NumPorts; p++) begin
      seq[p] = '0;
      for (int v = 0; v < NumVc; v++) begin
        up_cred[p][v]   = VcDepth;
        ds_cred[p][v]   = VcDepth;
        cred_pend[p][v] = 0;
        held[p][v]      = 0;
      end
    end
    repeat (ResetCycles) @(posedge clk_i);
    #0.5;
    reset_i = 1'b0;
    repeat (IdleCycles) begin
      @(posedge clk_i);
      #0.5;
      check_idle();
    end
    repeat (RandomCycles) step(1'b1, CreditRandom);
    // downstream keeps every credit so outputs stall once their counters run out
    repeat (StallCycles) step(1'b1, CreditNone);
    repeat (ResumeCycles) step(1'b1, CreditRandom);
    while (delivered < injected) step(1'b0, CreditAll);
    repeat (IdleCycles) step(1'b0, CreditAll);
    repeat (IdleCycles) begin
      @(posedge clk_i);
      #0.5;
      check_idle();
    end
    check_balance();
    $display("%0d flits injected and delivered", delivered);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: vc_router.f
hw/vc_router_pkg.sv
hw/vc_input_port.sv
hw/vc_switch_allocator.sv
hw/vc_crossbar.sv
hw/vc_router.sv
sim/vc_router_checker.sv
sim/vc_router_tb.sv

// File: Makefile
# Verilator flow for the VC router: lint, simulate, clean.
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= vc_router_tb
FILELIST  ?= vc_router.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
